/* verilog.f */
+incdir+include
source/lc3_pkg.sv
source/lc3_mem_port.sv
source/lc3_fetch.sv
source/lc3_decode.sv
source/lc3_execute.sv
source/lc3_mem_wb.sv
source/lc3_top.sv
sim/tb_lc3_mem.sv
sim/tb_lc3_top.sv

/* Makefile */
# Verilator build for the LC-3 pipeline testbench

TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_lc3_top
FLIST = verilog.f
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

# a failing check ends in $fatal, which gives a non-zero exit status
run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* sim/tb_lc3_top.sv */
`include "lc3_defs.svh"

module tb_lc3_top import lc3_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          HALT_TIMEOUT = 5000;
    localparam logic [15:0] TRAP_HALT    = {`LC3_OP_TRAP, 12'h025};

    logic                   clk;
    logic                   rst;
    logic                   fast;
    logic                   mem_req;
    mem_cmd_t               mem_cmd;
    logic                   mem_ack;
    logic [`LC3_WORD_W-1:0] mem_rdata;
    logic                   halted;
    logic                   proto_err;
    logic [`LC3_WORD_W-1:0] load_pc;  // next program address

    lc3_top i_dut (.clk, .rst, .mem_req, .mem_cmd, .mem_ack, .mem_rdata, .halted);

    tb_lc3_mem i_mem (.clk, .fast, .mem_req, .mem_cmd, .mem_ack, .mem_rdata, .proto_err);

    always #20 clk = ~clk;

    // --------------------
    // small assembler
    // --------------------
    function automatic logic [15:0] reg_form(input logic [3:0] op, input int dr, input int sr1,
                                             input int sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] imm_form(input logic [3:0] op, input int dr, input int sr1,
                                             input int imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] not_form(input int dr, input int sr);
        return {`LC3_OP_NOT, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    // offset is taken from the incremented pc of the word being placed
    function automatic logic [15:0] rel_form(input logic [3:0] op, input int r,
                                             input logic [15:0] target);
        logic [15:0] off;
        off = target - (load_pc + 16'd1);
        return {op, r[2:0], off[8:0]};
    endfunction

    function automatic logic [15:0] fill_value(input logic [15:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'h5AC3;
    endfunction

    task automatic place(input logic [15:0] word);
        i_mem.mem[load_pc] = word;
        load_pc = load_pc + 16'd1;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input logic [15:0] addr, input logic [15:0] expected,
                              input string name);
        logic [15:0] actual;
        actual = i_mem.mem[addr];
        assert (actual === expected) else
            stop_run($sformatf("ERR %0t %s mem[%h] expected %h actual %h",
                               $time, name, addr, expected, actual));
    endtask

    always @(posedge clk) begin
        #3;
        assert (proto_err !== 1'b1) else
            stop_run("the memory handshake rules were broken, see the memory model message");
    end

    // --------------------
    // run control
    // --------------------
    task automatic prepare(input logic fast_mode);
        int a;
        rst  = 1'b1;
        fast = fast_mode;
        for (a = 0; a < 65536; a++) i_mem.mem[a] = fill_value(16'(a));
        load_pc = `LC3_RESET_PC;
    endtask

    task automatic run_program();
        int   cnt;
        logic prev_req;
        repeat (10) next_cycle();
        assert (halted === 1'b0) else
            stop_run($sformatf("ERR %0t halted expected 0 actual %b", $time, halted));
        assert (mem_req === 1'b0) else
            stop_run($sformatf("ERR %0t mem_req expected 0 actual %b", $time, mem_req));
        rst = 1'b0;
        cnt = 0;
        while (halted !== 1'b1 && cnt < HALT_TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        assert (halted === 1'b1) else
            stop_run("timeout: halted never rose after the program's TRAP");
        prev_req = mem_req;  // a read already in flight may still finish
        repeat (50) begin
            next_cycle();
            assert (!(mem_req === 1'b1 && prev_req !== 1'b1)) else
                stop_run("a new memory request started after halted rose");
            assert (halted === 1'b1) else
                stop_run("halted dropped before reset");
            prev_req = mem_req;
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_operate(input logic fast_mode);
        logic [15:0] a;
        logic [15:0] b;
        a = 16'h1234;
        b = 16'h0F0F;
        prepare(fast_mode);
        i_mem.mem[16'h3030] = a;
        i_mem.mem[16'h3031] = b;
        place(rel_form(`LC3_OP_LD, 1, 16'h3030));
        place(rel_form(`LC3_OP_LD, 2, 16'h3031));
        place(reg_form(`LC3_OP_ADD, 3, 1, 2));
        place(rel_form(`LC3_OP_ST, 3, 16'h3040));
        place(imm_form(`LC3_OP_ADD, 4, 1, 7));
        place(rel_form(`LC3_OP_ST, 4, 16'h3041));
        place(imm_form(`LC3_OP_ADD, 5, 1, -16));  // most negative imm5
        place(rel_form(`LC3_OP_ST, 5, 16'h3042));
        place(reg_form(`LC3_OP_AND, 6, 1, 2));
        place(rel_form(`LC3_OP_ST, 6, 16'h3043));
        place(imm_form(`LC3_OP_AND, 7, 1, 13));
        place(rel_form(`LC3_OP_ST, 7, 16'h3044));
        place(not_form(0, 1));
        place(rel_form(`LC3_OP_ST, 0, 16'h3045));
        place(TRAP_HALT);
        run_program();
        check_word(16'h3040, a + b, "add_reg");
        check_word(16'h3041, a + 16'd7, "add_imm");
        check_word(16'h3042, a - 16'd16, "add_neg_imm");
        check_word(16'h3043, a & b, "and_reg");
        check_word(16'h3044, a & 16'd13, "and_imm");
        check_word(16'h3045, ~a, "not");
    endtask

    task automatic test_mem_addr();
        prepare(1'b1);
        i_mem.mem[16'h3030] = 16'h00A5;
        i_mem.mem[16'h3031] = 16'hBEEF;
        place(rel_form(`LC3_OP_LD, 1, 16'h3030));
        place(rel_form(`LC3_OP_LD, 2, 16'h3031));
        place(rel_form(`LC3_OP_ST, 1, 16'h3040));
        place(rel_form(`LC3_OP_ST, 2, 16'h3041));
        place(rel_form(`LC3_OP_LEA, 3, 16'h3031));
        place(rel_form(`LC3_OP_ST, 3, 16'h3042));
        place(rel_form(`LC3_OP_LEA, 4, 16'h3000));  // backward offset
        place(rel_form(`LC3_OP_ST, 4, 16'h3043));
        place(TRAP_HALT);
        run_program();
        check_word(16'h3040, 16'h00A5, "ld_first");
        check_word(16'h3041, 16'hBEEF, "ld_second");
        check_word(16'h3042, 16'h3031, "lea_label");
        check_word(16'h3043, 16'h3000, "lea_back");
    endtask

    task automatic test_branch();
        logic [15:0] marker;
        logic [15:0] neg;
        marker = 16'h00AA;
        neg    = 16'hFFF6;
        prepare(1'b1);
        i_mem.mem[16'h3030] = marker;
        i_mem.mem[16'h3031] = neg;
        place(rel_form(`LC3_OP_LD, 6, 16'h3030));
        place(rel_form(`LC3_OP_LD, 1, 16'h3031));   // cc n
        place(rel_form(`LC3_OP_BR, 3'b010, 16'h3004));
        place(rel_form(`LC3_OP_ST, 6, 16'h3040));
        place(rel_form(`LC3_OP_BR, 3'b100, 16'h3006));
        place(rel_form(`LC3_OP_ST, 6, 16'h3041));
        place(imm_form(`LC3_OP_ADD, 1, 1, 10));     // cc z
        place(rel_form(`LC3_OP_BR, 3'b001, 16'h3009));
        place(rel_form(`LC3_OP_ST, 6, 16'h3042));
        place(rel_form(`LC3_OP_BR, 3'b010, 16'h300B));
        place(rel_form(`LC3_OP_ST, 6, 16'h3043));
        place(imm_form(`LC3_OP_ADD, 1, 1, 3));      // cc p
        place(rel_form(`LC3_OP_BR, 3'b001, 16'h300E));
        place(rel_form(`LC3_OP_ST, 6, 16'h3044));
        place(rel_form(`LC3_OP_BR, 3'b111, 16'h3010));
        place(rel_form(`LC3_OP_ST, 6, 16'h3045));
        place(rel_form(`LC3_OP_ST, 1, 16'h3046));
        place(TRAP_HALT);
        run_program();
        check_word(16'h3040, marker, "brz_not_taken");
        check_word(16'h3041, fill_value(16'h3041), "brn_skipped");
        check_word(16'h3042, marker, "brp_not_taken");
        check_word(16'h3043, fill_value(16'h3043), "brz_skipped");
        check_word(16'h3044, fill_value(16'h3044), "brp_skipped");
        check_word(16'h3045, fill_value(16'h3045), "brnzp_skipped");
        check_word(16'h3046, neg + 16'd13, "after_branches");
    endtask

    task automatic test_hazard();
        logic [15:0] d0;
        logic [15:0] d1;
        logic [15:0] r2;
        logic [15:0] r3;
        d0 = 16'h0105;
        d1 = 16'h7000;
        r2 = d0 + d0 + 16'd3;
        r3 = r2 + r2 + d0;
        prepare(1'b1);
        i_mem.mem[16'h3030] = d0;
        i_mem.mem[16'h3031] = d1;
        place(rel_form(`LC3_OP_LD, 1, 16'h3030));
        place(reg_form(`LC3_OP_ADD, 2, 1, 1));      // consumer right after LD
        place(imm_form(`LC3_OP_ADD, 2, 2, 3));
        place(reg_form(`LC3_OP_ADD, 3, 2, 2));
        place(reg_form(`LC3_OP_ADD, 3, 3, 1));
        place(rel_form(`LC3_OP_LD, 4, 16'h3031));
        place(reg_form(`LC3_OP_ADD, 4, 4, 3));
        place(rel_form(`LC3_OP_ST, 4, 16'h3040));
        place(rel_form(`LC3_OP_ST, 2, 16'h3041));
        place(TRAP_HALT);
        run_program();
        check_word(16'h3040, d1 + r3, "chain_result");
        check_word(16'h3041, r2, "chain_middle");
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        fast    = 1'b1;
        load_pc = `LC3_RESET_PC;
        test_operate(1'b1);
        test_mem_addr();
        test_branch();
        test_hazard();
        test_operate(1'b0);  // same program under random ack delays
        $display(">>> PASS");
        $finish;
    end

endmodule

/* sim/tb_lc3_mem.sv */
`include "lc3_defs.svh"

module tb_lc3_mem import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   fast,       // force zero ack delays
    input  logic                   mem_req,
    input  mem_cmd_t               mem_cmd,
    output logic                   mem_ack,
    output logic [`LC3_WORD_W-1:0] mem_rdata,
    output logic                   proto_err
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`LC3_WORD_W-1:0] mem [0:65535];
    integer                 seed;
    mem_cmd_t               cmd;
    mem_cmd_t               prev_cmd;
    logic                   prev_req;
    logic                   prev_ack;

    function automatic int ack_delay();
        if (fast) return 0;
        return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // --------------------
    // four-phase responder
    // --------------------
    task automatic serve();
        int wait_cnt;
        cmd = mem_cmd;
        repeat (ack_delay()) next_cycle();
        if (cmd.we) mem[cmd.addr] = cmd.wdata;
        else mem_rdata = mem[cmd.addr];  // held while ack is high
        mem_ack  = 1'b1;
        wait_cnt = 0;
        while (mem_req === 1'b1 && wait_cnt < 100) begin
            next_cycle();
            wait_cnt++;
        end
        if (mem_req === 1'b1) begin
            $display("memory model: req still high 100 cycles after ack at %0t", $time);
            proto_err = 1'b1;
        end
        repeat (ack_delay()) next_cycle();
        mem_ack = 1'b0;
    endtask

    initial begin
        seed      = 11;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        proto_err = 1'b0;
        prev_req  = 1'b0;
        prev_ack  = 1'b0;
        prev_cmd  = '0;
        forever begin
            next_cycle();
            if (mem_req === 1'b1) serve();
        end
    end

    // --------------------
    // handshake rules
    // --------------------
    always @(posedge clk) begin
        #2;  // after the DUT edge and the responder
        if ((prev_req === 1'b1 || prev_ack === 1'b1) && mem_cmd !== prev_cmd) begin
            $display("memory model: mem_cmd changed during a handshake at %0t", $time);
            proto_err = 1'b1;
        end
        if (prev_req !== 1'b1 && mem_req === 1'b1 && prev_ack === 1'b1) begin
            $display("memory model: req rose while ack was still high at %0t", $time);
            proto_err = 1'b1;
        end
        prev_req = mem_req;
        prev_ack = mem_ack;
        prev_cmd = mem_cmd;
    end

endmodule

/* source/lc3_top.sv */
`include "lc3_defs.svh"

module lc3_top import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   mem_req,
    output mem_cmd_t               mem_cmd,
    input  logic                   mem_ack,
    input  logic [`LC3_WORD_W-1:0] mem_rdata,
    output logic                   halted
);

    logic                   fetch_req, fetch_done, data_req, data_done;
    logic [`LC3_WORD_W-1:0] fetch_addr, rdata, redirect_pc;
    mem_cmd_t               data_cmd;
    logic                   redirect, stop, pipe_empty, ex_busy, mw_busy;
    logic                   fd_valid, fd_ready, de_valid, de_ready, em_valid, em_ready;
    fetch_t                 fd;
    issue_t                 de;
    exec_t                  em;
    wb_t                    wb;

    assign pipe_empty = !(ex_busy || mw_busy);

    lc3_mem_port i_mem_port (
        .clk, .rst, .fetch_req, .fetch_addr, .fetch_done, .data_req, .data_cmd,
        .data_done, .rdata, .mem_req, .mem_cmd, .mem_ack, .mem_rdata
    );

    lc3_fetch i_fetch (
        .clk, .rst, .fetch_req, .fetch_addr, .fetch_done, .rdata, .redirect, .redirect_pc,
        .out_valid(fd_valid), .out_ready(fd_ready), .out(fd), .stop
    );

    lc3_decode i_decode (
        .clk, .rst, .in_valid(fd_valid), .in_ready(fd_ready), .in(fd),
        .out_valid(de_valid), .out_ready(de_ready), .out(de), .wb,
        .redirect, .redirect_pc, .stop, .halted, .pipe_empty
    );

    lc3_execute i_execute (
        .clk, .rst, .in_valid(de_valid), .in_ready(de_ready), .in(de),
        .out_valid(em_valid), .out_ready(em_ready), .out(em), .busy(ex_busy)
    );

    lc3_mem_wb i_mem_wb (
        .clk, .rst, .in_valid(em_valid), .in_ready(em_ready), .in(em),
        .data_req, .data_cmd, .data_done, .rdata, .wb, .busy(mw_busy)
    );

endmodule

/* source/lc3_mem_wb.sv */
`include "lc3_defs.svh"

module lc3_mem_wb import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exec_t                  in,
    output logic                   data_req,
    output mem_cmd_t               data_cmd,
    input  logic                   data_done,
    input  logic [`LC3_WORD_W-1:0] rdata,
    output wb_t                    wb,
    output logic                   busy
);

    exec_t cur;
    logic  is_mem;
    logic  retire;

    assign is_mem = (cur.op == op_ld) || (cur.op == op_st);
    assign retire = busy && (!is_mem || data_done);  // alu ops go in one cycle

    // request held until the port answers
    assign data_req = busy && is_mem;
    assign data_cmd = '{addr: cur.result, wdata: cur.sdata, we: cur.op == op_st};

    assign wb.valid  = retire && (cur.op != op_st);
    assign wb.dr     = cur.dr;
    assign wb.data   = (cur.op == op_ld) ? rdata : cur.result;
    assign wb.set_cc = cur.set_cc;

    assign in_ready = !busy || retire;

    always_ff @(posedge clk) begin
        if (rst) busy <= 1'b0;
        else if (in_valid && in_ready) busy <= 1'b1;
        else if (retire) busy <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) cur <= in;
    end

endmodule

/* source/lc3_execute.sv */
module lc3_execute import lc3_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  issue_t in,
    output logic   out_valid,
    input  logic   out_ready,
    output exec_t  out,
    output logic   busy
);

    exec_t res;

    always_comb begin
        res.op     = in.op;
        res.dr     = in.dr;
        res.sdata  = in.b;
        res.set_cc = in.set_cc;
        case (in.op)
            op_add:  res.result = in.a + in.b;
            op_and:  res.result = in.a & in.b;
            op_not:  res.result = ~in.a;
            default: res.result = in.pc_inc + in.offset;  // ld, st, lea address
        endcase
    end

    assign in_ready = !out_valid || out_ready;
    assign busy     = out_valid;

    always_ff @(posedge clk) begin
        if (rst) out_valid <= 1'b0;
        else if (in_valid && in_ready) out_valid <= 1'b1;
        else if (out_ready) out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) out <= res;
    end

endmodule

/* source/lc3_decode.sv */
`include "lc3_defs.svh"

module lc3_decode import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  fetch_t                 in,
    output logic                   out_valid,
    input  logic                   out_ready,
    output issue_t                 out,
    input  wb_t                    wb,
    output logic                   redirect,
    output logic [`LC3_WORD_W-1:0] redirect_pc,
    output logic                   stop,
    output logic                   halted,
    input  logic                   pipe_empty
);

    logic [`LC3_WORD_W-1:0] regs [`LC3_REG_N];
    logic [`LC3_REG_N-1:0]  pend;    // write outstanding per register
    logic [2:0]             cc_cnt;  // cc writers in flight
    logic                   flag_n, flag_z, flag_p;

    lc3_instr_u             instr;
    logic [3:0]             opcode;
    logic                   is_add, is_and, is_not, is_br, is_ld, is_st, is_lea, is_trap;
    logic                   use_sr1, use_sr2, use_dst, issue, set_cc;
    logic                   hazard, accept, taken, cc_inc, cc_dec;
    logic [`LC3_WORD_W-1:0] imm_ext, off_ext;
    op_kind_t               kind;

    // --------------------
    // decode
    // --------------------
    assign instr   = in.instr;
    assign opcode  = instr.op.opcode;
    assign is_add  = opcode == `LC3_OP_ADD;
    assign is_and  = opcode == `LC3_OP_AND;
    assign is_not  = opcode == `LC3_OP_NOT;
    assign is_br   = opcode == `LC3_OP_BR;
    assign is_ld   = opcode == `LC3_OP_LD;
    assign is_st   = opcode == `LC3_OP_ST;
    assign is_lea  = opcode == `LC3_OP_LEA;
    assign is_trap = opcode == `LC3_OP_TRAP;

    assign use_sr1 = is_add | is_and | is_not;
    assign use_sr2 = (is_add | is_and) & ~instr.op.imm_flag;
    assign use_dst = is_add | is_and | is_not | is_ld | is_lea;
    assign set_cc  = is_add | is_and | is_not | is_ld;  // lea leaves cc alone
    assign issue   = use_dst | is_st;

    assign imm_ext = {{11{instr.op.imm5_sr2[4]}}, instr.op.imm5_sr2};
    assign off_ext = {{7{instr.pco.pcoffset9[8]}}, instr.pco.pcoffset9};

    always_comb begin
        case (opcode)
            `LC3_OP_AND: kind = op_and;
            `LC3_OP_NOT: kind = op_not;
            `LC3_OP_LD:  kind = op_ld;
            `LC3_OP_ST:  kind = op_st;
            `LC3_OP_LEA: kind = op_lea;
            default:     kind = op_add;
        endcase
    end

    // --------------------
    // hazards and branch
    // --------------------
    assign hazard = (use_sr1 & pend[instr.op.sr1])
                  | (use_sr2 & pend[instr.op.imm5_sr2[2:0]])
                  | (use_dst & pend[instr.op.dr])
                  | (is_st & pend[instr.pco.reg_f])
                  | (is_br & (cc_cnt != 3'd0));

    assign in_ready    = !stop && !hazard && (!issue || !out_valid || out_ready);
    assign accept      = in_valid && in_ready;
    assign taken       = |(instr.pco.reg_f & {flag_n, flag_z, flag_p});
    assign redirect    = accept && is_br && taken;
    assign redirect_pc = in.pc_inc + off_ext;

    assign cc_inc = accept && set_cc;
    assign cc_dec = wb.valid && wb.set_cc;

    always_ff @(posedge clk) begin
        if (wb.valid) regs[wb.dr] <= wb.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {flag_n, flag_z, flag_p} <= 3'b010;
            pend   <= '0;
            cc_cnt <= 3'd0;
        end else begin
            if (cc_dec) begin
                flag_n <= wb.data[15];
                flag_z <= wb.data == '0;
                flag_p <= !wb.data[15] && (wb.data != '0);
            end
            if (wb.valid) pend[wb.dr] <= 1'b0;
            if (accept && use_dst) pend[instr.op.dr] <= 1'b1;  // after the clear
            if (cc_inc && !cc_dec) cc_cnt <= cc_cnt + 1'b1;
            else if (!cc_inc && cc_dec) cc_cnt <= cc_cnt - 1'b1;
        end
    end

    // --------------------
    // issue register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) out_valid <= 1'b0;
        else if (accept && issue) out_valid <= 1'b1;
        else if (out_ready) out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept && issue) begin
            out.op     <= kind;
            out.dr     <= instr.op.dr;
            out.a      <= regs[instr.op.sr1];
            out.pc_inc <= in.pc_inc;
            out.offset <= off_ext;
            out.set_cc <= set_cc;
            if (is_st) out.b <= regs[instr.pco.reg_f];  // store data
            else if (instr.op.imm_flag) out.b <= imm_ext;
            else out.b <= regs[instr.op.imm5_sr2[2:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stop   <= 1'b0;
            halted <= 1'b0;
        end else begin
            if (accept && is_trap) stop <= 1'b1;
            if (stop && pipe_empty && !out_valid && pend == '0) halted <= 1'b1;  // sticky
        end
    end

endmodule

/* source/lc3_fetch.sv */
`include "lc3_defs.svh"

module lc3_fetch import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   fetch_req,
    output logic [`LC3_WORD_W-1:0] fetch_addr,
    input  logic                   fetch_done,
    input  logic [`LC3_WORD_W-1:0] rdata,
    input  logic                   redirect,
    input  logic [`LC3_WORD_W-1:0] redirect_pc,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fetch_t                 out,
    input  logic                   stop
);

    logic [`LC3_WORD_W-1:0] pc;
    logic                   pending;     // read in flight
    logic                   hold_valid;
    fetch_t                 hold;
    logic                   take;
    logic                   start;

    assign fetch_req  = pending;
    assign fetch_addr = pc;
    assign out_valid  = hold_valid;
    assign out        = hold;

    assign take  = fetch_done && !redirect;
    assign start = !pending && !stop && !redirect && (!hold_valid || out_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `LC3_RESET_PC;
            pending    <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (fetch_done) begin
                pending <= 1'b0;
            end else if (start) begin
                pending <= 1'b1;
            end

            if (redirect) begin
                pc         <= redirect_pc;
                hold_valid <= 1'b0;                      // drop wrong-path item
            end else if (take) begin
                pc         <= pc + 1'b1;
                hold_valid <= 1'b1;
            end else if (out_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold.pc_inc <= pc + 1'b1;
            hold.instr  <= rdata;
        end
    end

endmodule

/* source/lc3_mem_port.sv */
`include "lc3_defs.svh"

module lc3_mem_port import lc3_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  logic [`LC3_WORD_W-1:0] fetch_addr,
    output logic                   fetch_done,
    input  logic                   data_req,
    input  mem_cmd_t               data_cmd,
    output logic                   data_done,
    output logic [`LC3_WORD_W-1:0] rdata,
    output logic                   mem_req,
    output mem_cmd_t               mem_cmd,
    input  logic                   mem_ack,
    input  logic [`LC3_WORD_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {s_idle, s_ack_hi, s_ack_lo, s_done} state_t;

    state_t state;
    logic   owner_data;  // transfer belongs to the data channel

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= s_idle;
            mem_req    <= 1'b0;
            owner_data <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (data_req || fetch_req) begin
                        mem_req    <= 1'b1;
                        owner_data <= data_req;  // data wins a tie
                        state      <= s_ack_hi;
                    end
                end
                s_ack_hi: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= s_ack_lo;
                    end
                end
                s_ack_lo: begin
                    if (!mem_ack) state <= s_done;
                end
                default: state <= s_idle;  // done lasts one cycle
            endcase
        end
    end

    // command latched at acceptance, held until the next one
    always_ff @(posedge clk) begin
        if (state == s_idle && data_req) begin
            mem_cmd <= data_cmd;
        end else if (state == s_idle && fetch_req) begin
            mem_cmd <= '{addr: fetch_addr, wdata: '0, we: 1'b0};
        end
        if (state == s_ack_hi && mem_ack) rdata <= mem_rdata;  // valid while ack high
    end

    assign data_done  = (state == s_done) && owner_data;
    assign fetch_done = (state == s_done) && !owner_data;

endmodule

/* source/lc3_pkg.sv */
`include "lc3_defs.svh"

package lc3_pkg;

    // --------------------
    // instruction word views
    // --------------------
    typedef struct packed {
        logic [3:0]            opcode;
        logic [`LC3_REG_W-1:0] dr;
        logic [`LC3_REG_W-1:0] sr1;
        logic                  imm_flag;  // 1: imm5, 0: sr2 in [2:0]
        logic [4:0]            imm5_sr2;
    } instr_op_t;

    typedef struct packed {
        logic [3:0]            opcode;
        logic [`LC3_REG_W-1:0] reg_f;     // dr, nzp or sr
        logic [8:0]            pcoffset9;
    } instr_pco_t;

    typedef union packed {
        instr_op_t  op;
        instr_pco_t pco;
    } lc3_instr_u;

    // --------------------
    // transfer records
    // --------------------
    typedef struct packed {
        logic [`LC3_WORD_W-1:0] addr;
        logic [`LC3_WORD_W-1:0] wdata;
        logic                   we;
    } mem_cmd_t;

    typedef struct packed {
        logic [`LC3_WORD_W-1:0] pc_inc;
        lc3_instr_u             instr;
    } fetch_t;

    typedef enum logic [2:0] {op_add, op_and, op_not, op_ld, op_st, op_lea} op_kind_t;

    typedef struct packed {
        op_kind_t               op;
        logic [`LC3_REG_W-1:0]  dr;
        logic [`LC3_WORD_W-1:0] a;
        logic [`LC3_WORD_W-1:0] b;       // imm, sr2 or store data
        logic [`LC3_WORD_W-1:0] pc_inc;
        logic [`LC3_WORD_W-1:0] offset;  // sign-extended pcoffset9
        logic                   set_cc;
    } issue_t;

    typedef struct packed {
        op_kind_t               op;
        logic [`LC3_REG_W-1:0]  dr;
        logic [`LC3_WORD_W-1:0] result;  // alu value or effective address
        logic [`LC3_WORD_W-1:0] sdata;
        logic                   set_cc;
    } exec_t;

    typedef struct packed {
        logic                   valid;
        logic [`LC3_REG_W-1:0]  dr;
        logic [`LC3_WORD_W-1:0] data;
        logic                   set_cc;
    } wb_t;

endpackage

/* include/lc3_defs.svh */
`ifndef LC3_DEFS_SVH
`define LC3_DEFS_SVH

// --------------------
// widths and sizes
// --------------------
`define LC3_WORD_W   16
`define LC3_REG_N    8
`define LC3_REG_W    3

`define LC3_RESET_PC 16'h3000  // first fetch after reset

// --------------------
// opcodes, bits 15:12
// --------------------
`define LC3_OP_BR    4'b0000
`define LC3_OP_ADD   4'b0001
`define LC3_OP_LD    4'b0010
`define LC3_OP_ST    4'b0011
`define LC3_OP_AND   4'b0101
`define LC3_OP_NOT   4'b1001
`define LC3_OP_LEA   4'b1110
`define LC3_OP_TRAP  4'b1111  // only halts the core here

`endif
